// File: source/cache_params_pkg.sv
/* cache line geometry */
`default_nettype none

package cache_params_pkg;

    // words per line as a power of two
    localparam int offset_width = 2;
    localparam int words_per_line = 1 << offset_width;

    localparam int addr_width = 26;

    // must stay a power of two, pointers wrap
    localparam int wb_depth = 4;
    localparam int wb_ptr_width = $clog2(wb_depth);

    typedef logic [31:0] word_t;

    typedef logic [words_per_line*$bits(word_t)-1:0] line_t;

    // line-aligned, offset bits already dropped
    typedef logic [addr_width-1:0] addr_t;

    typedef logic [wb_ptr_width-1:0] wb_ptr_t;

endpackage

`default_nettype wire

// File: source/mem_bus_pkg.sv
/* memory path bus structs */
`default_nettype none

package mem_bus_pkg;

    // line read from the L2
    typedef struct packed {
        cache_params_pkg::addr_t addr;
    } line_req_t;

    // one dirty line, used for the eviction push,
    // the write buffer slots and the memory write port
    typedef struct packed {
        cache_params_pkg::addr_t addr;
        cache_params_pkg::line_t line;
    } wb_entry_t;

endpackage

`default_nettype wire

// File: source/write_buffer.sv
/* write buffer for evicted lines */
`timescale 1ns/1ps
`default_nettype none

module write_buffer (
    input  wire                              clk,
    input  wire                              rstn,
    // eviction side
    input  wire                              evict_push,
    input  wire mem_bus_pkg::wb_entry_t      evict_entry,
    output logic                             wb_full,
    // lookup from the arbiter
    input  wire cache_params_pkg::addr_t     query_addr,
    output logic                             query_ok,
    output cache_params_pkg::line_t          query_data,
    // drain to memory
    output logic                             mem_wr_req,
    output mem_bus_pkg::wb_entry_t           mem_wr_entry,
    input  wire                              mem_wr_done
);

    mem_bus_pkg::wb_entry_t                entries [cache_params_pkg::wb_depth];
    logic [cache_params_pkg::wb_depth-1:0] valid;
    cache_params_pkg::wb_ptr_t             head;
    cache_params_pkg::wb_ptr_t             tail;
    logic                                  push_ok;
    logic                                  pop;

    // tail slot still occupied means every slot is
    assign wb_full = valid[tail];
    assign push_ok = evict_push & ~wb_full;
    assign pop = mem_wr_done & mem_wr_req;

    // oldest entry goes to memory
    assign mem_wr_entry = entries[head];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            entries[tail] <= evict_entry;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            head <= '0;
            tail <= '0;
            mem_wr_req <= 1'b0;
        end else begin
            if (push_ok) begin
                valid[tail] <= 1'b1;
                tail <= tail + 1'b1;
            end
            if (pop) begin
                valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            // drops for a cycle after each pop, then follows the new head
            mem_wr_req <= valid[head] & ~pop;
        end
    end

    // walk oldest to newest so the newest match wins
    always_comb begin
        cache_params_pkg::wb_ptr_t idx;
        query_ok = 1'b0;
        query_data = entries[head].line;
        for (int i = 0; i < cache_params_pkg::wb_depth; i++) begin
            idx = head + cache_params_pkg::wb_ptr_t'(i);
            if (valid[idx] && entries[idx].addr == query_addr) begin
                query_ok = 1'b1;
                query_data = entries[idx].line;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/wrt_ret_arbiter.sv
/* L2 line read arbiter */
`timescale 1ns/1ps
`default_nettype none

module wrt_ret_arbiter (
    input  wire                              clk,
    input  wire                              rstn,
    // L2 read side
    input  wire                              l2_req,
    input  wire mem_bus_pkg::line_req_t      l2_req_addr,
    output logic                             addr_ok,
    input  wire                              l2_rdy,
    output logic                             data_ok,
    output cache_params_pkg::line_t          l2_line,
    // write buffer lookup
    output cache_params_pkg::addr_t          query_addr,
    input  wire                              query_ok,
    input  wire cache_params_pkg::line_t     query_data,
    // return buffer
    output logic                             arbiter_mem_req,
    input  wire                              mem_arbiter_addrOK,
    input  wire                              mem_arbiter_dataOK,
    input  wire cache_params_pkg::line_t     dout_mem_arbiter
);

    typedef enum logic [2:0] {
        st_idle,
        st_wrt_addr,
        st_wrt_data,
        st_ret_addr,
        st_ret_data
    } state_t;

    state_t                  state;
    state_t                  state_nxt;
    cache_params_pkg::line_t hit_line;

    assign query_addr = l2_req_addr.addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (l2_req) begin
                    state_nxt = query_ok ? st_wrt_addr : st_ret_addr;
                end
            end
            st_wrt_addr: state_nxt = st_wrt_data;
            st_wrt_data: begin
                if (l2_rdy) begin
                    state_nxt = st_idle;
                end
            end
            st_ret_addr: begin
                if (mem_arbiter_addrOK) begin
                    state_nxt = st_ret_data;
                end
            end
            st_ret_data: begin
                if (l2_rdy && mem_arbiter_dataOK) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // snapshot of the hit, a later drain must not change it
    always_ff @(posedge clk) begin
        if (state == st_idle && l2_req && query_ok) begin
            hit_line <= query_data;
        end
    end

    always_comb begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        arbiter_mem_req = 1'b0;
        case (state)
            st_wrt_addr: addr_ok = 1'b1;
            st_wrt_data: data_ok = 1'b1;
            st_ret_addr: begin
                arbiter_mem_req = 1'b1;
                addr_ok = mem_arbiter_addrOK;
            end
            st_ret_data: data_ok = mem_arbiter_dataOK;
            default: ;
        endcase
    end

    // miss data passes straight through
    assign l2_line = (state == st_ret_data) ? dout_mem_arbiter : hit_line;

endmodule

`default_nettype wire

// File: source/return_buffer.sv
/* memory refill holder */
`timescale 1ns/1ps
`default_nettype none

module return_buffer (
    input  wire                              clk,
    input  wire                              rstn,
    // arbiter side
    input  wire                              arbiter_mem_req,
    input  wire cache_params_pkg::addr_t     req_addr,
    output logic                             mem_arbiter_addrOK,
    output logic                             mem_arbiter_dataOK,
    output cache_params_pkg::line_t          dout_mem_arbiter,
    input  wire                              l2_rdy,
    // memory read side
    output logic                             mem_rd_req,
    output cache_params_pkg::addr_t          mem_rd_addr,
    input  wire                              mem_rd_done,
    input  wire cache_params_pkg::line_t     mem_rd_line
);

    typedef enum logic [1:0] {
        st_idle,
        st_reading,
        st_holding
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            mem_arbiter_addrOK <= 1'b0;
        end else begin
            // one pulse as the memory read goes out
            mem_arbiter_addrOK <= (state == st_idle) & arbiter_mem_req;
            case (state)
                st_idle: begin
                    if (arbiter_mem_req) begin
                        state <= st_reading;
                    end
                end
                st_reading: begin
                    if (mem_rd_done) begin
                        state <= st_holding;
                    end
                end
                st_holding: begin
                    if (l2_rdy) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && arbiter_mem_req) begin
            mem_rd_addr <= req_addr;
        end
        if (state == st_reading && mem_rd_done) begin
            dout_mem_arbiter <= mem_rd_line;
        end
    end

    assign mem_rd_req = (state == st_reading);
    assign mem_arbiter_dataOK = (state == st_holding);

endmodule

`default_nettype wire

// File: source/l2_mem_path.sv
/* L2 memory read path */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_path (
    input  wire                              clk,
    input  wire                              rstn,
    // L2 read side
    input  wire                              l2_req,
    input  wire mem_bus_pkg::line_req_t      l2_req_addr,
    output logic                             addr_ok,
    output logic                             data_ok,
    output cache_params_pkg::line_t          l2_line,
    input  wire                              l2_rdy,
    // L2 eviction side
    input  wire                              evict_push,
    input  wire mem_bus_pkg::wb_entry_t      evict_entry,
    output logic                             wb_full,
    // memory write side
    output logic                             mem_wr_req,
    output mem_bus_pkg::wb_entry_t           mem_wr_entry,
    input  wire                              mem_wr_done,
    // memory read side
    output logic                             mem_rd_req,
    output cache_params_pkg::addr_t          mem_rd_addr,
    input  wire                              mem_rd_done,
    input  wire cache_params_pkg::line_t     mem_rd_line
);

    cache_params_pkg::addr_t query_addr;
    logic                    query_ok;
    cache_params_pkg::line_t query_data;
    logic                    arbiter_mem_req;
    logic                    mem_arbiter_addrOK;
    logic                    mem_arbiter_dataOK;
    cache_params_pkg::line_t dout_mem_arbiter;

    write_buffer u_write_buffer (
        .clk          (clk),
        .rstn         (rstn),
        .evict_push   (evict_push),
        .evict_entry  (evict_entry),
        .wb_full      (wb_full),
        .query_addr   (query_addr),
        .query_ok     (query_ok),
        .query_data   (query_data),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_entry (mem_wr_entry),
        .mem_wr_done  (mem_wr_done)
    );

    wrt_ret_arbiter u_arbiter (
        .clk                (clk),
        .rstn               (rstn),
        .l2_req             (l2_req),
        .l2_req_addr        (l2_req_addr),
        .addr_ok            (addr_ok),
        .l2_rdy             (l2_rdy),
        .data_ok            (data_ok),
        .l2_line            (l2_line),
        .query_addr         (query_addr),
        .query_ok           (query_ok),
        .query_data         (query_data),
        .arbiter_mem_req    (arbiter_mem_req),
        .mem_arbiter_addrOK (mem_arbiter_addrOK),
        .mem_arbiter_dataOK (mem_arbiter_dataOK),
        .dout_mem_arbiter   (dout_mem_arbiter)
    );

    // miss address is the same line address the lookup sees
    return_buffer u_return_buffer (
        .clk                (clk),
        .rstn               (rstn),
        .arbiter_mem_req    (arbiter_mem_req),
        .req_addr           (query_addr),
        .mem_arbiter_addrOK (mem_arbiter_addrOK),
        .mem_arbiter_dataOK (mem_arbiter_dataOK),
        .dout_mem_arbiter   (dout_mem_arbiter),
        .l2_rdy             (l2_rdy),
        .mem_rd_req         (mem_rd_req),
        .mem_rd_addr        (mem_rd_addr),
        .mem_rd_done        (mem_rd_done),
        .mem_rd_line        (mem_rd_line)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // low for three cycles, released between edges
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/l2_mem_path_tb.sv
/* testbench for the L2 memory read path */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_path_tb;

    localparam int wait_limit = 200;

    logic                    clk;
    logic                    rstn;
    logic                    l2_req;
    mem_bus_pkg::line_req_t  l2_req_addr;
    logic                    addr_ok;
    logic                    data_ok;
    cache_params_pkg::line_t l2_line;
    logic                    l2_rdy;
    logic                    evict_push;
    mem_bus_pkg::wb_entry_t  evict_entry;
    logic                    wb_full;
    logic                    mem_wr_req;
    mem_bus_pkg::wb_entry_t  mem_wr_entry;
    logic                    mem_wr_done;
    logic                    mem_rd_req;
    cache_params_pkg::addr_t mem_rd_addr;
    logic                    mem_rd_done;
    cache_params_pkg::line_t mem_rd_line;

    // last pushed line per address, and what memory holds
    cache_params_pkg::line_t expected_lines [cache_params_pkg::addr_t];
    cache_params_pkg::line_t mem_store [cache_params_pkg::addr_t];
    logic [15:0]             stim_lfsr = 16'd22940;
    logic [15:0]             mem_lfsr = 16'd22940;
    int                      error_count = 0;
    logic                    timed_out = 1'b0;

    tb_clock_gen clock_gen (.clk(clk), .rstn(rstn));

    l2_mem_path uut (.*);

    // galois form, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(state[0]);
            state = lfsr_step(state);
        end
    endtask

    // word i is base + i
    function automatic cache_params_pkg::line_t make_line(input logic [31:0] base);
        cache_params_pkg::line_t line;
        for (int i = 0; i < cache_params_pkg::words_per_line; i++) begin
            line[i*32 +: 32] = base + 32'(i);
        end
        return line;
    endfunction

    task automatic check_line(input string name, input cache_params_pkg::line_t expected,
                              input cache_params_pkg::line_t actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic note_timeout(input string name, input string what);
        $display("%s: timed out waiting for %s", name, what);
        error_count++;
        timed_out = 1'b1;
    endtask

    task automatic push_line(input cache_params_pkg::addr_t addr, input logic [31:0] seed,
                             input string name);
        int cnt;
        cnt = 0;
        while (wb_full && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (wb_full) begin
            note_timeout(name, "wb_full to fall before a push");
            return;
        end
        evict_entry.addr = addr;
        evict_entry.line = make_line(seed);
        evict_push = 1'b1;
        expected_lines[addr] = evict_entry.line;
        @(negedge clk);
        evict_push = 1'b0;
    endtask

    task automatic read_line(input cache_params_pkg::addr_t addr, input string name);
        cache_params_pkg::line_t expected;
        int cnt;
        int stall;
        expected = expected_lines.exists(addr) ? expected_lines[addr] : make_line(32'(addr));
        l2_req_addr.addr = addr;
        l2_req = 1'b1;
        cnt = 0;
        while (!addr_ok && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!addr_ok) begin
            l2_req = 1'b0;
            note_timeout(name, "addr_ok");
            return;
        end
        l2_req = 1'b0;
        // addr_ok is a one-cycle pulse
        @(negedge clk);
        check_line(name, 0, cache_params_pkg::line_t'(addr_ok));
        cnt = 0;
        while (!data_ok && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!data_ok) begin
            note_timeout(name, "data_ok");
            return;
        end
        check_line(name, expected, l2_line);
        // hold off the take for a few cycles
        draw_bits(stim_lfsr, 3, stall);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_line(name, 1, cache_params_pkg::line_t'(data_ok));
            check_line(name, expected, l2_line);
        end
        l2_rdy = 1'b1;
        @(negedge clk);
        l2_rdy = 1'b0;
        check_line(name, 0, cache_params_pkg::line_t'(data_ok));
    endtask

    task automatic fill_buffer(input cache_params_pkg::addr_t base, input logic [31:0] seed,
                               input string name);
        int k;
        k = 0;
        while (!wb_full && !timed_out && k < 16) begin
            push_line(base + cache_params_pkg::addr_t'(k), seed + 32'(k * 16), name);
            k++;
        end
        if (!wb_full && !timed_out) begin
            $display("%s: wb_full never rose after %0d pushes", name, k);
            error_count++;
        end
    endtask

    // a drained buffer is neither full nor writing
    task automatic idle_cycles(input logic [31:0] cycles, input string name);
        repeat (cycles) @(negedge clk);
        check_line(name, 0, cache_params_pkg::line_t'(wb_full));
        check_line(name, 0, cache_params_pkg::line_t'(mem_wr_req));
    endtask

    initial begin : memory_model
        int   wr_wait;
        int   rd_wait;
        logic wr_busy;
        logic rd_busy;
        wr_wait = 0;
        rd_wait = 0;
        wr_busy = 1'b0;
        rd_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (mem_wr_done) begin
                mem_wr_done = 1'b0;
            end else if (rstn && mem_wr_req) begin
                if (!wr_busy) begin
                    draw_bits(mem_lfsr, 3, wr_wait);
                    wr_busy = 1'b1;
                end
                if (wr_wait == 0) begin
                    mem_store[mem_wr_entry.addr] = mem_wr_entry.line;
                    mem_wr_done = 1'b1;
                    wr_busy = 1'b0;
                end else begin
                    wr_wait--;
                end
            end
            if (mem_rd_done) begin
                mem_rd_done = 1'b0;
            end else if (rstn && mem_rd_req) begin
                if (!rd_busy) begin
                    draw_bits(mem_lfsr, 3, rd_wait);
                    rd_busy = 1'b1;
                end
                if (rd_wait == 0) begin
                    mem_rd_line = mem_store.exists(mem_rd_addr) ? mem_store[mem_rd_addr]
                                                                : make_line(32'(mem_rd_addr));
                    mem_rd_done = 1'b1;
                    rd_busy = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
        end
    end

    initial begin : run_tests
        int          fd;
        int          fields;
        int          errors_before;
        int          test_count;
        int          failed_count;
        int          settle;
        string       text;
        string       kind;
        string       name;
        logic [31:0] addr_field;
        logic [31:0] seed_field;
        l2_req = 1'b0;
        l2_req_addr = '0;
        l2_rdy = 1'b0;
        evict_push = 1'b0;
        evict_entry = '0;
        mem_wr_done = 1'b0;
        mem_rd_done = 1'b0;
        mem_rd_line = '0;
        test_count = 0;
        failed_count = 0;
        settle = 0;
        while (rstn !== 1'b1 && settle < wait_limit) begin
            @(negedge clk);
            settle++;
        end
        if (rstn !== 1'b1) begin
            note_timeout("reset", "rstn to rise");
        end
        @(negedge clk);
        fd = $fopen("verification/mem_path_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/mem_path_tests.txt");
            error_count++;
        end
        while (fd != 0 && !timed_out && $fgets(text, fd) != 0) begin
            fields = $sscanf(text, "%s %h %h %s", kind, addr_field, seed_field, name);
            if (fields == 4 && kind.substr(0, 0) != "#") begin
                errors_before = error_count;
                if (kind == "push") begin
                    push_line(cache_params_pkg::addr_t'(addr_field), seed_field, name);
                end else if (kind == "read") begin
                    read_line(cache_params_pkg::addr_t'(addr_field), name);
                end else if (kind == "idle") begin
                    idle_cycles(seed_field, name);
                end else if (kind == "fill") begin
                    fill_buffer(cache_params_pkg::addr_t'(addr_field), seed_field, name);
                end else begin
                    $display("%s: unknown operation %s", name, kind);
                    error_count++;
                end
                test_count++;
                if (error_count != errors_before) begin
                    failed_count++;
                end
                $display("%s %s: %s", kind, name, (error_count == errors_before) ? "ok" : "fail");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_count, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/cache_params_pkg.sv
source/mem_bus_pkg.sv
source/write_buffer.sv
source/wrt_ret_arbiter.sv
source/return_buffer.sv
source/l2_mem_path.sv
verification/tb_clock_gen.sv
verification/l2_mem_path_tb.sv

// File: verification/mem_path_tests.txt
# kind address seed name, address and seed in hex
# push word i = seed + i, idle waits seed cycles, fill pushes address, address+1 ... until wb_full
read 0000100 00000000 never_evicted
push 0000200 a0000000 evict_a
read 0000200 00000000 hit_after_push
push 0000300 b0000000 evict_b_old
push 0000300 c0000000 evict_b_new
read 0000300 00000000 newer_push_wins
idle 0000000 00000040 drain_a_b
read 0000200 00000000 a_after_drain
read 0000300 00000000 b_after_drain
fill 0001000 d0000000 fill_until_full
read 0001002 00000000 full_read_2
read 0001000 00000000 full_read_0
read 0001003 00000000 full_read_3
read 0001001 00000000 full_read_1
read 0000100 00000000 miss_while_busy
idle 0000000 00000040 drain_after_full
read 0001003 00000000 read_3_from_memory
push 0000200 e0000000 evict_a_again
read 0000200 00000000 a_newest
read 3ffffff 00000000 never_evicted_top
